// File: rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  // funct3 codes for OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101; // srl, sra and the immediate forms
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 bit that selects sub and sra
  localparam int F7_ALT_BIT = 30;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB
  } alu_op_e;

endpackage

// File: rv_pipe_pkg.sv
package rv_pipe_pkg;

  typedef logic [31:0] word_t;    // data and pc
  typedef logic [4:0]  reg_idx_t; // architectural register index

  // where the alu takes operand a from
  typedef enum logic [1:0] {
    SRC_A_REG,
    SRC_A_PC,
    SRC_A_ZERO
  } src_a_e;

endpackage

// File: rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_isa_pkg::alu_op_e op_i,
  input  rv_pipe_pkg::word_t  a_i,
  input  rv_pipe_pkg::word_t  b_i,
  output rv_pipe_pkg::word_t  y_o
);
  import rv_isa_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:   y_o = a_i + b_i;
      ALU_SUB:   y_o = a_i - b_i;
      ALU_SLL:   y_o = a_i << shamt;
      ALU_SLT:   y_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU:  y_o = {31'b0, a_i < b_i};
      ALU_XOR:   y_o = a_i ^ b_i;
      ALU_SRL:   y_o = a_i >> shamt;
      ALU_SRA:   y_o = $unsigned($signed(a_i) >>> shamt); // sign fill
      ALU_OR:    y_o = a_i | b_i;
      ALU_AND:   y_o = a_i & b_i;
      ALU_PASSB: y_o = b_i;
      default:   y_o = '0;
    endcase
  end

endmodule

// File: rv_decode.sv
`timescale 1ns/100ps

module rv_decode #(
  parameter int REG_COUNT = 32
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  instr_valid_i,
  input  rv_pipe_pkg::word_t    instr_i,
  input  rv_pipe_pkg::word_t    instr_pc_i,
  output logic                  instr_ready_o,
  input  logic                  advance_i,
  output rv_pipe_pkg::reg_idx_t rf_raddr1_o,
  output rv_pipe_pkg::reg_idx_t rf_raddr2_o,
  input  rv_pipe_pkg::word_t    rf_rdata1_i,
  input  rv_pipe_pkg::word_t    rf_rdata2_i,
  output logic                  dx_valid_o,
  output rv_pipe_pkg::word_t    dx_pc_o,
  output rv_pipe_pkg::reg_idx_t dx_rs1_o,
  output rv_pipe_pkg::reg_idx_t dx_rs2_o,
  output rv_pipe_pkg::reg_idx_t dx_rd_o,
  output rv_pipe_pkg::word_t    dx_rs1_data_o,
  output rv_pipe_pkg::word_t    dx_rs2_data_o,
  output rv_pipe_pkg::word_t    dx_imm_o,
  output rv_isa_pkg::alu_op_e   dx_alu_op_o,
  output rv_pipe_pkg::src_a_e   dx_src_a_o,
  output logic                  dx_imm_v_o,
  output logic                  dx_wr_v_o,
  output logic                  dx_illegal_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  logic     alt;
  word_t    imm_i_type;
  word_t    imm_u_type;
  word_t    imm;
  alu_op_e  alu_op;
  src_a_e   src_a;
  logic     imm_v;
  logic     opc_ok;
  logic     use_rs1;
  logic     use_rs2;
  logic     illegal;

  function automatic alu_op_e map_alu(input logic [2:0] f3, input logic alt_b, input logic is_op);
    case (f3)
      F3_ADD:  return (alt_b && is_op) ? ALU_SUB : ALU_ADD; // no subi in the isa
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SRL:  return alt_b ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign rs1        = instr_i[19:15];
  assign rs2        = instr_i[24:20];
  assign rd         = instr_i[11:7];
  assign alt        = instr_i[F7_ALT_BIT];
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  assign rf_raddr1_o   = rs1;
  assign rf_raddr2_o   = rs2;
  assign instr_ready_o = advance_i;

  always_comb begin
    opc_ok  = 1'b1;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    imm_v   = 1'b1;
    imm     = imm_i_type;
    src_a   = SRC_A_REG;
    alu_op  = ALU_ADD;
    case (instr_i[6:0])
      OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm_v   = 1'b0;
        alu_op  = map_alu(instr_i[14:12], alt, 1'b1);
      end
      OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        alu_op  = map_alu(instr_i[14:12], alt, 1'b0);
      end
      OPC_LUI: begin
        imm    = imm_u_type;
        src_a  = SRC_A_ZERO;
        alu_op = ALU_PASSB;
      end
      OPC_AUIPC: begin
        imm   = imm_u_type;
        src_a = SRC_A_PC;
      end
      default: opc_ok = 1'b0;
    endcase
    illegal = !opc_ok || (int'(rd) >= REG_COUNT)
              || (use_rs1 && (int'(rs1) >= REG_COUNT))
              || (use_rs2 && (int'(rs2) >= REG_COUNT));
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dx_valid_o   <= 1'b0;
      dx_wr_v_o    <= 1'b0;
      dx_illegal_o <= 1'b0;
    end else if (advance_i) begin
      dx_valid_o   <= instr_valid_i;
      dx_wr_v_o    <= !illegal;
      dx_illegal_o <= illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      dx_pc_o       <= instr_pc_i;
      dx_rs1_o      <= rs1;
      dx_rs2_o      <= rs2;
      dx_rd_o       <= rd;
      dx_rs1_data_o <= rf_rdata1_i; // includes write-through from result
      dx_rs2_data_o <= rf_rdata2_i;
      dx_imm_o      <= imm;
      dx_alu_op_o   <= alu_op;
      dx_src_a_o    <= src_a;
      dx_imm_v_o    <= imm_v;
    end
  end

  // the source must hold a stalled instruction unchanged
  instr_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    instr_valid_i && !instr_ready_o |=> instr_valid_i && $stable(instr_i) && $stable(instr_pc_i));

endmodule

// File: rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  advance_i,
  input  logic                  dx_valid_i,
  input  rv_pipe_pkg::word_t    dx_pc_i,
  input  rv_pipe_pkg::reg_idx_t dx_rs1_i,
  input  rv_pipe_pkg::reg_idx_t dx_rs2_i,
  input  rv_pipe_pkg::reg_idx_t dx_rd_i,
  input  rv_pipe_pkg::word_t    dx_rs1_data_i,
  input  rv_pipe_pkg::word_t    dx_rs2_data_i,
  input  rv_pipe_pkg::word_t    dx_imm_i,
  input  rv_isa_pkg::alu_op_e   dx_alu_op_i,
  input  rv_pipe_pkg::src_a_e   dx_src_a_i,
  input  logic                  dx_imm_v_i,
  input  logic                  dx_wr_v_i,
  input  logic                  dx_illegal_i,
  output logic                  xr_valid_o,
  output rv_pipe_pkg::reg_idx_t xr_rd_o,
  output rv_pipe_pkg::word_t    xr_result_o,
  output rv_pipe_pkg::word_t    xr_pc_o,
  output logic                  xr_wr_v_o,
  output logic                  xr_illegal_o
);
  import rv_pipe_pkg::*;

  logic  fwd_ok;
  word_t rs1_val;
  word_t rs2_val;
  word_t op_a;
  word_t op_b;
  word_t alu_y;

  // instruction one ahead sits in the xr register
  assign fwd_ok  = xr_valid_o && xr_wr_v_o && (xr_rd_o != '0);
  assign rs1_val = (fwd_ok && (xr_rd_o == dx_rs1_i)) ? xr_result_o : dx_rs1_data_i;
  assign rs2_val = (fwd_ok && (xr_rd_o == dx_rs2_i)) ? xr_result_o : dx_rs2_data_i;
  assign op_b    = dx_imm_v_i ? dx_imm_i : rs2_val;

  always_comb begin
    case (dx_src_a_i)
      SRC_A_PC:   op_a = dx_pc_i;
      SRC_A_ZERO: op_a = '0;
      default:    op_a = rs1_val;
    endcase
  end

  rv_alu u_alu (
    .op_i (dx_alu_op_i),
    .a_i  (op_a),
    .b_i  (op_b),
    .y_o  (alu_y)
  );

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      xr_valid_o   <= 1'b0;
      xr_wr_v_o    <= 1'b0;
      xr_illegal_o <= 1'b0;
    end else if (advance_i) begin
      xr_valid_o   <= dx_valid_i;
      xr_wr_v_o    <= dx_wr_v_i;
      xr_illegal_o <= dx_illegal_i;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      xr_rd_o     <= dx_rd_i;
      xr_result_o <= alu_y;
      xr_pc_o     <= dx_pc_i;
    end
  end

  // an illegal instruction must never reach write-back with a write enable
  no_illegal_write_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    dx_valid_i |-> !(dx_illegal_i && dx_wr_v_i));

endmodule

// File: rv_result.sv
`timescale 1ns/100ps

module rv_result #(
  parameter int REG_COUNT = 32
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  xr_valid_i,
  input  rv_pipe_pkg::reg_idx_t xr_rd_i,
  input  rv_pipe_pkg::word_t    xr_result_i,
  input  rv_pipe_pkg::word_t    xr_pc_i,
  input  logic                  xr_wr_v_i,
  input  logic                  xr_illegal_i,
  input  logic                  res_ready_i,
  output logic                  res_valid_o,
  output rv_pipe_pkg::reg_idx_t res_rd_o,
  output rv_pipe_pkg::word_t    res_data_o,
  output rv_pipe_pkg::word_t    res_pc_o,
  output logic                  res_illegal_o,
  output logic                  advance_o,
  input  rv_pipe_pkg::reg_idx_t rf_raddr1_i,
  input  rv_pipe_pkg::reg_idx_t rf_raddr2_i,
  output rv_pipe_pkg::word_t    rf_rdata1_o,
  output rv_pipe_pkg::word_t    rf_rdata2_o
);
  import rv_pipe_pkg::*;

  localparam int IDX_W = $clog2(REG_COUNT);

  word_t regs [1:REG_COUNT-1]; // x0 has no storage
  logic  wr_en;

  function automatic word_t rf_read(input reg_idx_t addr);
    if (addr == '0 || int'(addr) >= REG_COUNT) begin
      return '0;
    end else if (wr_en && addr == xr_rd_i) begin
      return xr_result_i; // write-through
    end else begin
      return regs[addr[IDX_W-1:0]];
    end
  endfunction

  assign advance_o = !xr_valid_i || res_ready_i;
  assign wr_en     = xr_valid_i && xr_wr_v_i && advance_o && (xr_rd_i != '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[xr_rd_i[IDX_W-1:0]] <= xr_result_i;
    end
  end

  always_comb begin
    rf_rdata1_o = rf_read(rf_raddr1_i);
    rf_rdata2_o = rf_read(rf_raddr2_i);
  end

  assign res_valid_o   = xr_valid_i;
  assign res_rd_o      = xr_rd_i;
  assign res_data_o    = xr_result_i;
  assign res_pc_o      = xr_pc_i;
  assign res_illegal_o = xr_illegal_i;

  // a held result must not change until the sink takes it
  res_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_rd_o) && $stable(res_data_o)
    && $stable(res_pc_o) && $stable(res_illegal_o));

endmodule

// File: rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top #(
  parameter int REG_COUNT = 32
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  instr_valid_i,
  input  rv_pipe_pkg::word_t    instr_i,
  input  rv_pipe_pkg::word_t    instr_pc_i,
  output logic                  instr_ready_o,
  input  logic                  res_ready_i,
  output logic                  res_valid_o,
  output rv_pipe_pkg::reg_idx_t res_rd_o,
  output rv_pipe_pkg::word_t    res_data_o,
  output rv_pipe_pkg::word_t    res_pc_o,
  output logic                  res_illegal_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic     advance;
  reg_idx_t rf_raddr1;
  reg_idx_t rf_raddr2;
  word_t    rf_rdata1;
  word_t    rf_rdata2;

  logic     dx_valid;
  word_t    dx_pc;
  reg_idx_t dx_rs1;
  reg_idx_t dx_rs2;
  reg_idx_t dx_rd;
  word_t    dx_rs1_data;
  word_t    dx_rs2_data;
  word_t    dx_imm;
  alu_op_e  dx_alu_op;
  src_a_e   dx_src_a;
  logic     dx_imm_v;
  logic     dx_wr_v;
  logic     dx_illegal;

  logic     xr_valid;
  reg_idx_t xr_rd;
  word_t    xr_result;
  word_t    xr_pc;
  logic     xr_wr_v;
  logic     xr_illegal;

  rv_decode #(
    .REG_COUNT (REG_COUNT)
  ) u_decode (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_pc_i    (instr_pc_i),
    .instr_ready_o (instr_ready_o),
    .advance_i     (advance),
    .rf_raddr1_o   (rf_raddr1),
    .rf_raddr2_o   (rf_raddr2),
    .rf_rdata1_i   (rf_rdata1),
    .rf_rdata2_i   (rf_rdata2),
    .dx_valid_o    (dx_valid),
    .dx_pc_o       (dx_pc),
    .dx_rs1_o      (dx_rs1),
    .dx_rs2_o      (dx_rs2),
    .dx_rd_o       (dx_rd),
    .dx_rs1_data_o (dx_rs1_data),
    .dx_rs2_data_o (dx_rs2_data),
    .dx_imm_o      (dx_imm),
    .dx_alu_op_o   (dx_alu_op),
    .dx_src_a_o    (dx_src_a),
    .dx_imm_v_o    (dx_imm_v),
    .dx_wr_v_o     (dx_wr_v),
    .dx_illegal_o  (dx_illegal)
  );

  rv_execute u_execute (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .advance_i     (advance),
    .dx_valid_i    (dx_valid),
    .dx_pc_i       (dx_pc),
    .dx_rs1_i      (dx_rs1),
    .dx_rs2_i      (dx_rs2),
    .dx_rd_i       (dx_rd),
    .dx_rs1_data_i (dx_rs1_data),
    .dx_rs2_data_i (dx_rs2_data),
    .dx_imm_i      (dx_imm),
    .dx_alu_op_i   (dx_alu_op),
    .dx_src_a_i    (dx_src_a),
    .dx_imm_v_i    (dx_imm_v),
    .dx_wr_v_i     (dx_wr_v),
    .dx_illegal_i  (dx_illegal),
    .xr_valid_o    (xr_valid),
    .xr_rd_o       (xr_rd),
    .xr_result_o   (xr_result),
    .xr_pc_o       (xr_pc),
    .xr_wr_v_o     (xr_wr_v),
    .xr_illegal_o  (xr_illegal)
  );

  rv_result #(
    .REG_COUNT (REG_COUNT)
  ) u_result (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .xr_valid_i    (xr_valid),
    .xr_rd_i       (xr_rd),
    .xr_result_i   (xr_result),
    .xr_pc_i       (xr_pc),
    .xr_wr_v_i     (xr_wr_v),
    .xr_illegal_i  (xr_illegal),
    .res_ready_i   (res_ready_i),
    .res_valid_o   (res_valid_o),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .res_pc_o      (res_pc_o),
    .res_illegal_o (res_illegal_o),
    .advance_o     (advance),
    .rf_raddr1_i   (rf_raddr1),
    .rf_raddr2_i   (rf_raddr2),
    .rf_rdata1_o   (rf_rdata1),
    .rf_rdata2_o   (rf_rdata2)
  );

endmodule

// File: tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int          ACCEPT_TIMEOUT = 100;
  localparam int          DRAIN_TIMEOUT  = 300;
  localparam logic [31:0] SEED           = 32'h9e47_53a4;

  logic     clk;
  logic     arst_n_i;
  logic     instr_valid_i;
  word_t    instr_i;
  word_t    instr_pc_i;
  logic     instr_ready_o;
  logic     res_ready_i;
  logic     res_valid_o;
  reg_idx_t res_rd_o;
  word_t    res_data_o;
  word_t    res_pc_o;
  logic     res_illegal_o;

  // stimulus table with one entry per instruction in program order
  word_t    instr_q [$];
  word_t    pc_q [$];
  reg_idx_t rd_q [$];
  word_t    data_q [$];
  logic     ill_q [$];
  int       ret_cnt;
  int       chain_first; // first and last row of the dependency chain
  int       chain_last;

  rv_core_top #(
    .REG_COUNT (32)
  ) u_rv_core_top (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_pc_i    (instr_pc_i),
    .instr_ready_o (instr_ready_o),
    .res_ready_i   (res_ready_i),
    .res_valid_o   (res_valid_o),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .res_pc_o      (res_pc_o),
    .res_illegal_o (res_illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      abort_run("result check failed");
    end
  endtask

  function automatic word_t enc_r(input logic alt, input int rd, input int rs1, input int rs2,
                                  input logic [2:0] f3);
    return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic word_t enc_i(input int rd, input int rs1, input logic [11:0] imm,
                                  input logic [2:0] f3);
    return {imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
  endfunction

  function automatic word_t enc_u(input opcode_e opc, input int rd, input logic [19:0] imm);
    return {imm, 5'(rd), opc};
  endfunction

  task automatic add_row(input word_t instr, input int rd, input word_t data, input logic ill);
    pc_q.push_back(32'h1000 + 4 * instr_q.size());
    instr_q.push_back(instr);
    rd_q.push_back(5'(rd));
    data_q.push_back(data);
    ill_q.push_back(ill);
  endtask

  task automatic load_table();
    add_row(enc_u(OPC_LUI, 1, 20'h12345), 1, 32'h1234_5000, 1'b0);
    add_row(enc_i(1, 1, 12'h678, F3_ADD), 1, 32'h1234_5678, 1'b0);
    add_row(enc_i(2, 0, 12'hfff, F3_ADD), 2, 32'hffff_ffff, 1'b0); // addi -1
    add_row(enc_i(3, 0, 12'h800, F3_ADD), 3, 32'hffff_f800, 1'b0); // addi -2048
    add_row(enc_i(4, 2, 12'h000, F3_SLT), 4, 32'h0000_0001, 1'b0);
    add_row(enc_i(5, 2, 12'h001, F3_SLTU), 5, 32'h0000_0000, 1'b0);
    add_row(enc_i(6, 1, 12'hfff, F3_XOR), 6, 32'hedcb_a987, 1'b0);
    add_row(enc_i(7, 0, 12'h0f0, F3_OR), 7, 32'h0000_00f0, 1'b0);
    add_row(enc_i(8, 1, 12'h0ff, F3_AND), 8, 32'h0000_0078, 1'b0);
    add_row(enc_i(9, 1, 12'h004, F3_SLL), 9, 32'h2345_6780, 1'b0);
    add_row(enc_i(10, 3, 12'h004, F3_SRL), 10, 32'h0fff_ff80, 1'b0);
    add_row(enc_i(11, 3, 12'h404, F3_SRL), 11, 32'hffff_ff80, 1'b0); // srai
    add_row(enc_u(OPC_LUI, 12, 20'h80000), 12, 32'h8000_0000, 1'b0);
    add_row(enc_i(13, 0, 12'h001, F3_ADD), 13, 32'h0000_0001, 1'b0);
    add_row(enc_r(1'b0, 14, 1, 2, F3_ADD), 14, 32'h1234_5677, 1'b0);
    add_row(enc_r(1'b1, 15, 12, 13, F3_ADD), 15, 32'h7fff_ffff, 1'b0); // sub wraps
    add_row(enc_r(1'b0, 16, 12, 13, F3_SLT), 16, 32'h0000_0001, 1'b0);
    add_row(enc_r(1'b0, 17, 12, 13, F3_SLTU), 17, 32'h0000_0000, 1'b0);
    add_row(enc_r(1'b0, 18, 13, 2, F3_SLT), 18, 32'h0000_0000, 1'b0);
    add_row(enc_r(1'b0, 19, 13, 2, F3_SLTU), 19, 32'h0000_0001, 1'b0);
    add_row(enc_r(1'b0, 20, 1, 7, F3_SLL), 20, 32'h5678_0000, 1'b0); // shamt 0xf0 & 31
    add_row(enc_r(1'b0, 21, 12, 13, F3_SRL), 21, 32'h4000_0000, 1'b0);
    add_row(enc_r(1'b1, 22, 12, 13, F3_SRL), 22, 32'hc000_0000, 1'b0);
    add_row(enc_r(1'b0, 23, 1, 6, F3_XOR), 23, 32'hffff_ffff, 1'b0);
    add_row(enc_r(1'b0, 24, 7, 13, F3_OR), 24, 32'h0000_00f1, 1'b0);
    add_row(enc_r(1'b0, 25, 1, 10, F3_AND), 25, 32'h0234_5600, 1'b0);
    // dependency chain at distance one and two
    chain_first = instr_q.size();
    add_row(enc_i(26, 0, 12'h005, F3_ADD), 26, 32'd5, 1'b0);
    add_row(enc_r(1'b0, 27, 26, 26, F3_ADD), 27, 32'd10, 1'b0);
    add_row(enc_r(1'b0, 28, 27, 26, F3_ADD), 28, 32'd15, 1'b0);
    add_row(enc_r(1'b1, 26, 28, 26, F3_ADD), 26, 32'd10, 1'b0);
    add_row(enc_r(1'b0, 29, 26, 28, F3_ADD), 29, 32'd25, 1'b0);
    chain_last = instr_q.size() - 1;
    add_row(enc_u(OPC_AUIPC, 30, 20'h00001), 30, 32'h0000_207c, 1'b0); // pc 0x107c
    add_row(enc_i(0, 0, 12'h007, F3_ADD), 0, 32'd7, 1'b0);
    add_row(enc_r(1'b0, 31, 0, 13, F3_ADD), 31, 32'd1, 1'b0);
    add_row(enc_i(30, 0, 12'h003, F3_ADD), 30, 32'd3, 1'b0);
    add_row({12'h004, 5'd0, 3'b010, 5'd5, 7'b0000011}, 5, 32'h0, 1'b1); // load opcode
    add_row(enc_i(5, 5, 12'h001, F3_ADD), 5, 32'd1, 1'b0);
    add_row({20'h00010, 5'd1, 7'b1101111}, 1, 32'h0, 1'b1); // jal opcode
    add_row(enc_i(2, 1, 12'h000, F3_ADD), 2, 32'h1234_5678, 1'b0);
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!instr_ready_o) begin
      cycles++;
      if (cycles > ACCEPT_TIMEOUT) begin
        abort_run("timeout waiting for instr_ready_o");
      end
      @(posedge clk);
    end
  endtask

  initial begin
    int gap;
    int cycles;
    void'($urandom(SEED));
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    instr_pc_i    = '0;
    res_ready_i   = 1'b0;
    ret_cnt       = 0;
    load_table();
    repeat (3) @(posedge clk);
    arst_n_i <= 1'b1;
    for (int row = 0; row < instr_q.size(); row++) begin
      if (row > chain_first && row <= chain_last) begin
        gap = 0; // chain enters back to back to hit forwarding and write-through
      end else begin
        gap = int'($urandom_range(0, 2));
      end
      repeat (gap) begin
        instr_valid_i <= 1'b0;
        @(posedge clk);
      end
      instr_valid_i <= 1'b1;
      instr_i       <= instr_q[row];
      instr_pc_i    <= pc_q[row];
      wait_accept();
    end
    instr_valid_i <= 1'b0;
    cycles = 0;
    while (ret_cnt < instr_q.size()) begin
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        abort_run("timeout waiting for the last results to retire");
      end
      @(posedge clk);
    end
    repeat (4) @(posedge clk); // a duplicated result would show up here
    $display("Finished with no errors");
    $finish;
  end

  // sink drops ready about one cycle in four
  always @(posedge clk) begin
    if (arst_n_i) begin
      res_ready_i <= ($urandom_range(0, 3) != 0);
    end
  end

  always @(posedge clk) begin
    if (arst_n_i && res_valid_o && res_ready_i) begin
      if (ret_cnt >= instr_q.size()) begin
        abort_run("a result retired with no instruction left to match it");
      end else begin
        check_value($sformatf("row %0d pc", ret_cnt), res_pc_o, pc_q[ret_cnt]);
        check_value($sformatf("row %0d rd", ret_cnt), {27'b0, res_rd_o}, {27'b0, rd_q[ret_cnt]});
        check_value($sformatf("row %0d illegal", ret_cnt), {31'b0, res_illegal_o},
                    {31'b0, ill_q[ret_cnt]});
        if (!ill_q[ret_cnt]) begin
          check_value($sformatf("row %0d data", ret_cnt), res_data_o, data_q[ret_cnt]);
        end
        ret_cnt <= ret_cnt + 1;
      end
    end
  end

endmodule

// File: flist.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_alu.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_rv_core -o tb_rv_core \
  && ./obj_dir/tb_rv_core > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2> /dev/null
grep -q "Finished with no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
